/* sources.f */
source/csr_pkg.sv
source/csr_bus_port.sv
source/csr_trap_regs.sv
source/csr_interrupt_ctrl.sv
source/csr_timer.sv
source/csr_save_bank.sv
source/csr_read_mux.sv
source/csr_unit.sv
test/csr_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module csr_unit_tb \
  -f sources.f -o csr_unit_sim \
  && ./obj_dir/csr_unit_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "test passed" sim.log || { echo "No pass message in sim.log"; exit 1; }
echo "Simulation PASSED"

/* test/csr_unit_tb.sv */
`default_nettype none

module csr_unit_tb
  import csr_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS      = 5;
  localparam int TEST_BUDGET_NS = 2000;
  localparam int ACK_LIMIT      = 4;
  localparam int TIMER_LIMIT    = 40;

  logic                    clk;
  logic                    reset;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  csr_num_t                wb_adr;
  logic [3:0]              wb_sel;
  csr_word_t               wb_dat_w;
  logic                    wb_ack;
  csr_word_t               wb_dat_r;
  trap_event_t             trap;
  logic                    eret;
  logic [HW_INT_LINES-1:0] hw_int;
  logic                    ipi_int;
  logic                    has_int;

  int seed = 96;
  int cycle_count = 0;
  int test_errors;
  int total_errors = 0;
  int check_count = 0;
  int tests_run = 0;
  int tests_failed = 0;

  csr_unit dut_i (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w,
    .wb_ack, .wb_dat_r,
    .trap, .eret, .hw_int, .ipi_int, .has_int
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
  end

  function automatic csr_word_t random_word();
    return $random(seed);
  endfunction

  task automatic compare_word(input string name, input csr_word_t expected,
                              input csr_word_t actual);
    check_count++;
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected 0x%h, got 0x%h",
               $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Returns 1 ns after the edge where ack is seen, then ends the cycle
  task automatic wait_ack(input csr_num_t num);
    int waited;
    waited = 1;
    @(posedge clk);
    #1;
    while (!wb_ack && waited < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_count++;
    assert (wb_ack) else begin
      $display("Bus cycle to CSR 0x%h got no ack within %0d cycles", num, ACK_LIMIT);
      test_errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input csr_num_t num, input csr_word_t data, input logic [3:0] sel);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = num;
    wb_sel   = sel;
    wb_dat_w = data;
    wait_ack(num);
  endtask

  task automatic bus_read(input csr_num_t num, output csr_word_t data);
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = num;
    wb_sel = 4'hf;
    wait_ack(num);
    data = wb_dat_r;
  endtask

  task automatic pulse_trap(input ecode_t ecode, input esubcode_t esubcode,
                            input csr_word_t pc, input csr_word_t vaddr);
    @(posedge clk);
    #1;
    trap.ex       = 1'b1;
    trap.ecode    = ecode;
    trap.esubcode = esubcode;
    trap.pc       = pc;
    trap.vaddr    = vaddr;
    wait_cycles(1);
    trap = '0;
  endtask

  task automatic pulse_eret();
    @(posedge clk);
    #1;
    eret = 1'b1;
    wait_cycles(1);
    eret = 1'b0;
  endtask

  task automatic begin_test();
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
      $display("[%0t ns] %-24s FAIL, %0d errors", $time, name, test_errors);
    end else begin
      $display("[%0t ns] %-24s ok", $time, name);
    end
  endtask

  task automatic reset_state_test();
    csr_word_t rd;
    begin_test();
    bus_read(CSR_CRMD, rd);
    // DA reads 1, everything else 0
    compare_word("CRMD", 32'h8, rd);
    bus_read(CSR_ECFG, rd);
    compare_word("ECFG", 32'h0, rd);
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT", 32'h0, rd);
    bus_read(CSR_TVAL, rd);
    compare_word("TVAL", 32'hffff_ffff, rd);
    compare_word("has_int", 32'h0, {31'b0, has_int});
    bus_read(14'h3ff, rd);
    compare_word("CSR 0x3ff", 32'h0, rd);
    end_test("reset state");
  endtask

  task automatic masked_write_test();
    csr_word_t save_data [4];
    csr_word_t rd;
    csr_word_t upd;
    csr_word_t expected;
    csr_num_t  num;
    begin_test();
    for (int i = 0; i < 4; i++) begin
      num = CSR_SAVE0 + csr_num_t'(i);
      save_data[i] = random_word();
      bus_write(num, save_data[i], 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      num = CSR_SAVE0 + csr_num_t'(i);
      bus_read(num, rd);
      compare_word($sformatf("SAVE%0d", i), save_data[i], rd);
    end
    // Only bytes 0 and 2 take the new word
    upd = random_word();
    bus_write(CSR_SAVE1, upd, 4'h5);
    expected = (upd & 32'h00ff_00ff) | (save_data[1] & 32'hff00_ff00);
    bus_read(CSR_SAVE1, rd);
    compare_word("SAVE1", expected, rd);
    upd = random_word();
    bus_write(CSR_EENTRY, upd, 4'hf);
    bus_read(CSR_EENTRY, rd);
    compare_word("EENTRY", upd & ~32'h3f, rd);
    end_test("masked writes");
  endtask

  task automatic trap_return_test();
    csr_word_t rd;
    csr_word_t pc;
    csr_word_t vaddr;
    begin_test();
    bus_write(CSR_CRMD, 32'h7, 4'h1);
    bus_read(CSR_CRMD, rd);
    compare_word("CRMD", 32'hf, rd);
    pc    = random_word();
    vaddr = random_word();
    pulse_trap(ECODE_ALE, 9'h0, pc, vaddr);
    bus_read(CSR_CRMD, rd);
    compare_word("CRMD", 32'h8, rd);
    bus_read(CSR_PRMD, rd);
    compare_word("PRMD", 32'h7, rd);
    bus_read(CSR_ERA, rd);
    compare_word("ERA", pc, rd);
    bus_read(CSR_BADV, rd);
    compare_word("BADV", vaddr, rd);
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT[30:16]", 32'h9, {17'b0, rd[30:16]});
    pulse_eret();
    bus_read(CSR_CRMD, rd);
    compare_word("CRMD", 32'hf, rd);
    // Fetch fault reports the pc in BADV
    // PLV 1 with IE clear, so PRMD differs from the first trap
    bus_write(CSR_CRMD, 32'h1, 4'h1);
    pc    = random_word();
    vaddr = random_word();
    pulse_trap(ECODE_ADE, 9'h0, pc, vaddr);
    bus_read(CSR_CRMD, rd);
    compare_word("CRMD", 32'h8, rd);
    bus_read(CSR_BADV, rd);
    compare_word("BADV", pc, rd);
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT[30:16]", 32'h8, {17'b0, rd[30:16]});
    bus_read(CSR_PRMD, rd);
    compare_word("PRMD", 32'h1, rd);
    pulse_eret();
    bus_read(CSR_CRMD, rd);
    compare_word("CRMD", 32'h9, rd);
    end_test("trap entry and return");
  endtask

  task automatic oneshot_timer_test();
    csr_word_t rd;
    csr_word_t prev;
    int        start;
    begin_test();
    bus_write(CSR_CRMD, 32'h0, 4'h1);
    bus_write(CSR_ECFG, 32'h800, 4'hf);
    // INITVAL 5, one-shot, enabled
    bus_write(CSR_TCFG, 32'h15, 4'hf);
    start = cycle_count;
    prev  = 32'd21;
    for (int i = 0; i < 4; i++) begin
      bus_read(CSR_TVAL, rd);
      check_count++;
      assert (rd < prev) else begin
        $display("** Error at %0t ns: TVAL expected below 0x%h, got 0x%h", $time, prev, rd);
        test_errors++;
      end
      prev = rd;
    end
    bus_read(CSR_ESTAT, rd);
    while (!rd[TIMER_INT_BIT] && (cycle_count - start) < TIMER_LIMIT) begin
      bus_read(CSR_ESTAT, rd);
    end
    check_count++;
    assert (rd[TIMER_INT_BIT]) else begin
      $display("No timer interrupt within %0d cycles of the TCFG write", TIMER_LIMIT);
      test_errors++;
    end
    bus_read(CSR_TVAL, rd);
    compare_word("TVAL", 32'hffff_ffff, rd);
    compare_word("has_int", 32'h0, {31'b0, has_int});
    bus_write(CSR_CRMD, 32'h4, 4'h1);
    compare_word("has_int", 32'h1, {31'b0, has_int});
    bus_write(CSR_TICLR, 32'h1, 4'h1);
    compare_word("has_int", 32'h0, {31'b0, has_int});
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT[11]", 32'h0, {31'b0, rd[TIMER_INT_BIT]});
    end_test("one-shot timer");
  endtask

  task automatic interrupt_line_test();
    logic [12:0] masks [6];
    logic [12:0] exp_is;
    logic [7:0]  hw_val;
    logic        exp_int;
    csr_word_t   rd;
    begin_test();
    bus_write(CSR_CRMD, 32'h4, 4'h1);
    bus_write(CSR_ECFG, 32'h0, 4'hf);
    rd     = random_word();
    hw_val = rd[7:0];
    hw_int = hw_val;
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT[9:2]", {24'b0, hw_val}, {24'b0, rd[9:2]});
    ipi_int = 1'b1;
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT[12]", 32'h1, {31'b0, rd[12]});
    bus_write(CSR_ESTAT, 32'h3, 4'h1);
    bus_read(CSR_ESTAT, rd);
    compare_word("ESTAT[1:0]", 32'h3, {30'b0, rd[1:0]});
    // IPI, hardware lines and both software bits, timer cleared
    exp_is = {1'b1, 1'b0, 1'b0, hw_val, 2'b11};
    compare_word("ESTAT[12:0]", {19'b0, exp_is}, {19'b0, rd[12:0]});
    masks[0] = 13'h0000;
    masks[1] = 13'h0003;
    masks[2] = 13'h03fc;
    masks[3] = 13'h0800;
    masks[4] = 13'h1000;
    rd       = random_word();
    masks[5] = rd[12:0];
    for (int i = 0; i < 6; i++) begin
      bus_write(CSR_ECFG, {19'b0, masks[i]}, 4'h3);
      exp_int = (exp_is[11:0] & masks[i][11:0]) != 12'h0;
      compare_word($sformatf("has_int (LIE 0x%h)", masks[i]),
                   {31'b0, exp_int}, {31'b0, has_int});
    end
    bus_write(CSR_ECFG, 32'h0fff, 4'h3);
    bus_write(CSR_CRMD, 32'h0, 4'h1);
    compare_word("has_int (ie 0)", 32'h0, {31'b0, has_int});
    end_test("interrupt lines");
  endtask

  initial begin
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    trap     = '0;
    eret     = 1'b0;
    hw_int   = '0;
    ipi_int  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_state_test();
    masked_write_test();
    trap_return_test();
    oneshot_timer_test();
    interrupt_line_test();
    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, check_count, total_errors);
    if (total_errors == 0 && tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Each test gets a fixed share of simulated time
  initial begin
    #(NUM_TESTS * TEST_BUDGET_NS);
    $display("Watchdog expired after %0d ns before all tests finished",
             NUM_TESTS * TEST_BUDGET_NS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/csr_unit.sv */
`default_nettype none

module csr_unit
  import csr_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  csr_num_t                wb_adr,
  input  logic [3:0]              wb_sel,
  input  csr_word_t               wb_dat_w,
  output logic                    wb_ack,
  output csr_word_t               wb_dat_r,
  input  trap_event_t             trap,
  input  logic                    eret,
  input  logic [HW_INT_LINES-1:0] hw_int,
  input  logic                    ipi_int,
  output logic                    has_int
);

  csr_write_t           wr;
  csr_word_t            rd_data;
  crmd_t                crmd;
  crmd_t                prmd;
  csr_word_t            era;
  csr_word_t            badv;
  csr_word_t            eentry;
  ecode_t               ecode;
  esubcode_t            esubcode;
  logic [INT_LINES-1:0] ecfg_lie;
  logic [INT_LINES-1:0] estat_is;
  csr_word_t            tcfg;
  csr_word_t            tval;
  logic                 timer_int_set;
  logic                 timer_int_clear;
  csr_word_t [3:0]      save;

  csr_bus_port bus_port_i (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w,
    .wb_ack, .wb_dat_r,
    .rd_data, .wr
  );

  csr_trap_regs trap_regs_i (
    .clk, .reset, .wr, .trap, .eret,
    .crmd, .prmd, .era, .badv, .eentry, .ecode, .esubcode
  );

  csr_interrupt_ctrl interrupt_ctrl_i (
    .clk, .reset, .wr, .hw_int, .ipi_int,
    .timer_int_set, .timer_int_clear, .crmd,
    .ecfg_lie, .estat_is, .has_int
  );

  csr_timer timer_i (
    .clk, .reset, .wr, .tcfg, .tval, .timer_int_set, .timer_int_clear
  );

  csr_save_bank save_bank_i (
    .clk, .wr, .save
  );

  // Reads decode the bus address directly
  csr_read_mux read_mux_i (
    .num(wb_adr),
    .crmd, .prmd, .era, .badv, .eentry, .ecode, .esubcode,
    .ecfg_lie, .estat_is, .tcfg, .tval, .save,
    .rd_data
  );

endmodule

`default_nettype wire

/* source/csr_read_mux.sv */
`default_nettype none

module csr_read_mux
  import csr_pkg::*;
(
  input  csr_num_t             num,
  input  crmd_t                crmd,
  input  crmd_t                prmd,
  input  csr_word_t            era,
  input  csr_word_t            badv,
  input  csr_word_t            eentry,
  input  ecode_t               ecode,
  input  esubcode_t            esubcode,
  input  logic [INT_LINES-1:0] ecfg_lie,
  input  logic [INT_LINES-1:0] estat_is,
  input  csr_word_t            tcfg,
  input  csr_word_t            tval,
  input  csr_word_t [3:0]      save,
  output csr_word_t            rd_data
);

  csr_word_t crmd_rv;
  csr_word_t estat_rv;

  // DA is fixed at 1 with no paging support
  assign crmd_rv  = {28'b0, 1'b1, crmd};
  assign estat_rv = {1'b0, esubcode, ecode, 3'b0, estat_is};

  always_comb begin
    case (num)
      CSR_CRMD:   rd_data = crmd_rv;
      CSR_PRMD:   rd_data = {29'b0, prmd};
      CSR_ECFG:   rd_data = {19'b0, ecfg_lie};
      CSR_ESTAT:  rd_data = estat_rv;
      CSR_ERA:    rd_data = era;
      CSR_BADV:   rd_data = badv;
      CSR_EENTRY: rd_data = {eentry[31:6], 6'b0};
      CSR_SAVE0:  rd_data = save[0];
      CSR_SAVE1:  rd_data = save[1];
      CSR_SAVE2:  rd_data = save[2];
      CSR_SAVE3:  rd_data = save[3];
      CSR_TCFG:   rd_data = tcfg;
      CSR_TVAL:   rd_data = tval;
      // TICLR is write-only
      CSR_TICLR:  rd_data = '0;
      default:    rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/csr_save_bank.sv */
`default_nettype none

module csr_save_bank
  import csr_pkg::*;
(
  input  logic            clk,
  input  csr_write_t      wr,
  output csr_word_t [3:0] save
);

  logic      save_hit;
  logic [1:0] save_idx;

  // SAVE0..3 sit on four consecutive numbers
  assign save_hit = wr.valid && wr.num[13:2] == CSR_SAVE0[13:2];
  assign save_idx = wr.num[1:0];

  always_ff @(posedge clk) begin
    if (save_hit) begin
      save[save_idx] <= masked_update(save[save_idx], wr);
    end
  end

endmodule

`default_nettype wire

/* source/csr_timer.sv */
`default_nettype none

module csr_timer
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  csr_write_t wr,
  output csr_word_t  tcfg,
  output csr_word_t  tval,
  output logic       timer_int_set,
  output logic       timer_int_clear
);

  logic        tcfg_en;
  logic        tcfg_periodic;
  logic [29:0] tcfg_initval;
  logic        tcfg_wr;
  csr_word_t   tcfg_wv;
  csr_word_t   timer_cnt;

  assign tcfg    = {tcfg_initval, tcfg_periodic, tcfg_en};
  assign tcfg_wr = wr.valid && wr.num == CSR_TCFG;
  assign tcfg_wv = masked_update(tcfg, wr);

  always_ff @(posedge clk) begin
    if (reset) begin
      tcfg_en <= 1'b0;
    end else if (tcfg_wr) begin
      tcfg_en <= tcfg_wv[0];
    end
  end

  always_ff @(posedge clk) begin
    if (tcfg_wr) begin
      tcfg_periodic <= tcfg_wv[1];
      tcfg_initval  <= tcfg_wv[31:2];
    end
  end

  // Countdown in units of 4 cycles of INITVAL
  always_ff @(posedge clk) begin
    if (reset) begin
      timer_cnt <= TIMER_STOPPED;
    end else if (tcfg_wr && tcfg_wv[0]) begin
      timer_cnt <= {tcfg_wv[31:2], 2'b0};
    end else if (tcfg_en && timer_cnt != TIMER_STOPPED) begin
      if (timer_cnt == '0) begin
        timer_cnt <= tcfg_periodic ? {tcfg_initval, 2'b0} : TIMER_STOPPED;
      end else begin
        timer_cnt <= timer_cnt - 32'd1;
      end
    end
  end

  assign tval = timer_cnt;

  assign timer_int_set   = tcfg_en && timer_cnt == '0;
  assign timer_int_clear = wr.valid && wr.num == CSR_TICLR && wr.mask[0] && wr.data[0];

endmodule

`default_nettype wire

/* source/csr_interrupt_ctrl.sv */
`default_nettype none

module csr_interrupt_ctrl
  import csr_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  csr_write_t              wr,
  input  logic [HW_INT_LINES-1:0] hw_int,
  input  logic                    ipi_int,
  input  logic                    timer_int_set,
  input  logic                    timer_int_clear,
  input  crmd_t                   crmd,
  output logic [INT_LINES-1:0]    ecfg_lie,
  output logic [INT_LINES-1:0]    estat_is,
  output logic                    has_int
);

  csr_word_t ecfg_wv;
  csr_word_t estat_wv;

  assign ecfg_wv  = masked_update({19'b0, ecfg_lie}, wr);
  assign estat_wv = masked_update({19'b0, estat_is}, wr);

  always_ff @(posedge clk) begin
    if (reset) begin
      ecfg_lie <= '0;
    end else if (wr.valid && wr.num == CSR_ECFG) begin
      ecfg_lie <= ecfg_wv[INT_LINES-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      estat_is <= '0;
    end else begin
      // Software interrupts
      if (wr.valid && wr.num == CSR_ESTAT) begin
        estat_is[1:0] <= estat_wv[1:0];
      end
      estat_is[HW_INT_LINES+1:2] <= hw_int;
      estat_is[10]               <= 1'b0;
      if (timer_int_set) begin
        estat_is[TIMER_INT_BIT] <= 1'b1;
      end else if (timer_int_clear) begin
        estat_is[TIMER_INT_BIT] <= 1'b0;
      end
      estat_is[12] <= ipi_int;
    end
  end

  assign has_int = ((estat_is[11:0] & ecfg_lie[11:0]) != 12'b0) && crmd.ie;

endmodule

`default_nettype wire

/* source/csr_trap_regs.sv */
`default_nettype none

module csr_trap_regs
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  csr_write_t  wr,
  input  trap_event_t trap,
  input  logic        eret,
  output crmd_t       crmd,
  output crmd_t       prmd,
  output csr_word_t   era,
  output csr_word_t   badv,
  output csr_word_t   eentry,
  output ecode_t      ecode,
  output esubcode_t   esubcode
);

  logic        bus_ok;
  logic        addr_err;
  logic        use_pc;
  logic [25:0] eentry_va;
  csr_word_t   crmd_wv;
  csr_word_t   prmd_wv;
  csr_word_t   era_wv;
  csr_word_t   badv_wv;
  csr_word_t   eentry_wv;

  // Traps and eret win over bus writes
  assign bus_ok = wr.valid && !trap.ex && !eret;

  assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);
  assign use_pc   = (trap.ecode == ECODE_ADE) && (trap.esubcode == ESUBCODE_ADEF);

  assign crmd_wv   = masked_update({29'b0, crmd}, wr);
  assign prmd_wv   = masked_update({29'b0, prmd}, wr);
  assign era_wv    = masked_update(era, wr);
  assign badv_wv   = masked_update(badv, wr);
  assign eentry_wv = masked_update(eentry, wr);

  always_ff @(posedge clk) begin
    if (reset) begin
      crmd <= '0;
      prmd <= '0;
    end else if (trap.ex) begin
      crmd <= '0;
      prmd <= crmd;
    end else if (eret) begin
      crmd <= prmd;
    end else if (bus_ok) begin
      if (wr.num == CSR_CRMD) begin
        crmd <= crmd_t'(crmd_wv[2:0]);
      end
      if (wr.num == CSR_PRMD) begin
        prmd <= crmd_t'(prmd_wv[2:0]);
      end
    end
  end

  // ESTAT cause fields
  always_ff @(posedge clk) begin
    if (reset) begin
      ecode    <= '0;
      esubcode <= '0;
    end else if (trap.ex) begin
      ecode    <= trap.ecode;
      esubcode <= trap.esubcode;
    end
  end

  always_ff @(posedge clk) begin
    if (trap.ex) begin
      era <= trap.pc;
      // Fetch faults report the pc itself
      if (addr_err) begin
        badv <= use_pc ? trap.pc : trap.vaddr;
      end
    end else if (bus_ok) begin
      if (wr.num == CSR_ERA) begin
        era <= era_wv;
      end
      if (wr.num == CSR_BADV) begin
        badv <= badv_wv;
      end
      if (wr.num == CSR_EENTRY) begin
        eentry_va <= eentry_wv[31:6];
      end
    end
  end

  // Entry is 64-byte aligned
  assign eentry = {eentry_va, 6'b0};

endmodule

`default_nettype wire

/* source/csr_bus_port.sv */
`default_nettype none

module csr_bus_port
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  csr_num_t   wb_adr,
  input  logic [3:0] wb_sel,
  input  csr_word_t  wb_dat_w,
  output logic       wb_ack,
  output csr_word_t  wb_dat_r,
  input  csr_word_t  rd_data,
  output csr_write_t wr
);

  logic accept;

  // A new cycle is taken only while ack is low
  assign accept = wb_cyc && wb_stb && !wb_ack;

  assign wr.valid = accept && wb_we;
  assign wr.num   = wb_adr;
  assign wr.data  = wb_dat_w;
  assign wr.mask  = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= accept;
    end
  end

  // Old value of the register, before a write at the same edge
  always_ff @(posedge clk) begin
    if (accept) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  typedef logic [13:0] csr_num_t;
  typedef logic [31:0] csr_word_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;

  // Register numbers
  localparam csr_num_t CSR_CRMD   = 14'h0;
  localparam csr_num_t CSR_PRMD   = 14'h1;
  localparam csr_num_t CSR_ECFG   = 14'h4;
  localparam csr_num_t CSR_ESTAT  = 14'h5;
  localparam csr_num_t CSR_ERA    = 14'h6;
  localparam csr_num_t CSR_BADV   = 14'h7;
  localparam csr_num_t CSR_EENTRY = 14'hc;
  localparam csr_num_t CSR_SAVE0  = 14'h30;
  localparam csr_num_t CSR_SAVE1  = 14'h31;
  localparam csr_num_t CSR_SAVE2  = 14'h32;
  localparam csr_num_t CSR_SAVE3  = 14'h33;
  localparam csr_num_t CSR_TCFG   = 14'h41;
  localparam csr_num_t CSR_TVAL   = 14'h42;
  localparam csr_num_t CSR_TICLR  = 14'h44;

  // Exception causes
  localparam ecode_t    ECODE_ADE     = 6'h8;
  localparam ecode_t    ECODE_ALE     = 6'h9;
  localparam esubcode_t ESUBCODE_ADEF = 9'h0;

  localparam int INT_LINES     = 13;
  localparam int HW_INT_LINES  = 8;
  localparam int TIMER_INT_BIT = 11;

  localparam csr_word_t TIMER_STOPPED = 32'hffff_ffff;

  typedef struct packed {
    logic      valid;
    csr_num_t  num;
    csr_word_t data;
    csr_word_t mask;
  } csr_write_t;

  typedef struct packed {
    logic      ex;
    ecode_t    ecode;
    esubcode_t esubcode;
    csr_word_t pc;
    csr_word_t vaddr;
  } trap_event_t;

  // Field order follows the CRMD/PRMD bit layout, IE above PLV
  typedef struct packed {
    logic       ie;
    logic [1:0] plv;
  } crmd_t;

  // Byte-masked merge of a bus write into a register value
  function automatic csr_word_t masked_update(csr_word_t cur, csr_write_t w);
    return (w.data & w.mask) | (cur & ~w.mask);
  endfunction

endpackage

`default_nettype wire
